// ==== files.f ====
+incdir+hw
+incdir+tb
hw/rasterizerPkg.sv
hw/triangleSetup.sv
hw/edgeWalker.sv
hw/fragmentFormatter.sv
hw/rasterizer.sv
tb/rasterizerTb.sv

// ==== hw/edgeWalker.sv ====
// Serpentine edge walker
// Steps the three edge values across the bounding box and emits covered pixels
`timescale 1ns/1ps
`include "rasterizer_defines.svh"

module edgeWalker
(
    input  logic                   clk,
    input  logic                   reset,
    input  rasterizerPkg::walkJobT job,
    input  logic                   jobValid,
    output logic                   walkerIdle,
    output rasterizerPkg::pixelPosT pos,
    output logic                   posValid,
    input  logic                   posReady
);
    rasterizerPkg::walkStateT state;
    rasterizerPkg::walkDirT   dir;
    // Limits and increments of the current job
    rasterizerPkg::walkJobT   jobReg;

    logic                    active;
    logic                    tryOtherSide;
    logic [`COORD_WIDTH-1:0] x;
    logic [`COORD_WIDTH-1:0] yScreen;
    logic [`COORD_WIDTH-1:0] yRel;
    logic [`ATTR_WIDTH-1:0]  w0;
    logic [`ATTR_WIDTH-1:0]  w1;
    logic [`ATTR_WIDTH-1:0]  w2;

    logic inTriangle;
    logic hit;
    logic stepEnable;
    logic lineStep;
    logic pixelStep;

    // A pixel is covered when no edge value is negative
    assign inTriangle = !(w0[`ATTR_WIDTH-1] | w1[`ATTR_WIDTH-1] | w2[`ATTR_WIDTH-1]);
    assign hit        = inTriangle && (x < jobReg.bbEndX) && (x >= jobReg.bbStartX);

    // The whole walker freezes while the formatter cannot take a pixel
    assign stepEnable = active && posReady;

    // checkDir never moves, leaving the box after a line step guards x against wrap
    assign lineStep  = (state == rasterizerPkg::walk) && !hit;
    assign pixelStep = (state != rasterizerPkg::checkDir) && !lineStep;

    function automatic logic [`ATTR_WIDTH-1:0] stepEdge(
        input logic [`ATTR_WIDTH-1:0] w,
        input logic [`ATTR_WIDTH-1:0] incX,
        input logic [`ATTR_WIDTH-1:0] incY,
        input logic                   doLine,
        input logic                   doPixel,
        input logic                   goRight
    );
        if (doLine)
            return w + incY;
        else if (doPixel)
            return goRight ? w + incX : w - incX;
        else
            return w;
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active       <= 1'b0;
            posValid     <= 1'b0;
            state        <= rasterizerPkg::walkInit;
            dir          <= rasterizerPkg::right;
            tryOtherSide <= 1'b0;
        end
        else if (!active)
        begin
            if (jobValid)
            begin
                active       <= 1'b1;
                state        <= rasterizerPkg::walkInit;
                dir          <= rasterizerPkg::right;
                tryOtherSide <= 1'b0;
            end
        end
        else if (stepEnable)
        begin
            if (yScreen < jobReg.yScreenEnd)
            begin
                // Only the three scanning states may report a covered pixel
                posValid <= 1'b0;
                case (state)
                rasterizerPkg::walkInit:
                begin
                    posValid <= hit;
                    state    <= hit ? rasterizerPkg::walk : rasterizerPkg::searchEdge;
                end
                rasterizerPkg::checkDir:
                begin
                    // Inside after a line step: walk on to the far edge first
                    if (inTriangle)
                    begin
                        state <= rasterizerPkg::walkOut;
                    end
                    else
                    begin
                        // The triangle usually continues in the other direction
                        dir   <= (dir == rasterizerPkg::right) ? rasterizerPkg::left
                                                               : rasterizerPkg::right;
                        state <= rasterizerPkg::searchEdge;
                    end
                end
                rasterizerPkg::searchEdge:
                begin
                    if (hit)
                    begin
                        tryOtherSide <= 1'b0;
                        posValid     <= 1'b1;
                        state        <= rasterizerPkg::walk;
                    end
                    else if (x == jobReg.bbEndX)
                    begin
                        // Both sides searched without a hit, so the line is empty
                        if ((dir == rasterizerPkg::right) && tryOtherSide)
                        begin
                            tryOtherSide <= 1'b0;
                            state        <= rasterizerPkg::walk;
                        end
                        else
                        begin
                            tryOtherSide <= 1'b1;
                            dir          <= rasterizerPkg::left;
                        end
                    end
                    else if (x == jobReg.bbStartX)
                    begin
                        if ((dir == rasterizerPkg::left) && tryOtherSide)
                        begin
                            tryOtherSide <= 1'b0;
                            state        <= rasterizerPkg::walk;
                        end
                        else
                        begin
                            tryOtherSide <= 1'b1;
                            dir          <= rasterizerPkg::right;
                        end
                    end
                end
                rasterizerPkg::walkOut:
                begin
                    if (!inTriangle || (x == jobReg.bbStartX) || (x >= jobReg.bbEndX))
                    begin
                        dir   <= (dir == rasterizerPkg::right) ? rasterizerPkg::left
                                                               : rasterizerPkg::right;
                        state <= rasterizerPkg::searchEdge;
                    end
                end
                default:
                begin
                    // Span ends at the first uncovered pixel
                    posValid <= hit;
                    if (!hit)
                        state <= rasterizerPkg::checkDir;
                end
                endcase
            end
            else
            begin
                // Past the last line of the band or the box
                posValid <= 1'b0;
                active   <= 1'b0;
            end
        end
    end

    // Walk position, edge values and job data
    always_ff @(posedge clk)
    begin
        if (!active && jobValid)
        begin
            jobReg  <= job;
            x       <= job.startX;
            yScreen <= job.yScreen;
            yRel    <= job.yRel;
            w0      <= job.w0;
            w1      <= job.w1;
            w2      <= job.w2;
        end
        else if (stepEnable)
        begin
            // Position sampled before the step, paired with posValid above
            pos <= '{x: x, yScreen: yScreen, yRel: yRel,
                     bbStartX: jobReg.bbStartX, bbStartY: jobReg.bbStartY};
            if (lineStep)
            begin
                yScreen <= yScreen + 1'b1;
                yRel    <= yRel + 1'b1;
            end
            else if (pixelStep)
            begin
                x <= (dir == rasterizerPkg::right) ? x + 1'b1 : x - 1'b1;
            end
            w0 <= stepEdge(w0, jobReg.w0IncX, jobReg.w0IncY, lineStep, pixelStep,
                           dir == rasterizerPkg::right);
            w1 <= stepEdge(w1, jobReg.w1IncX, jobReg.w1IncY, lineStep, pixelStep,
                           dir == rasterizerPkg::right);
            w2 <= stepEdge(w2, jobReg.w2IncX, jobReg.w2IncY, lineStep, pixelStep,
                           dir == rasterizerPkg::right);
        end
    end

    assign walkerIdle = !active;

endmodule

// ==== hw/fragmentFormatter.sv ====
// Fragment output register
// Turns a pixel position into a framebuffer index and box relative coordinates
`timescale 1ns/1ps
`include "rasterizer_defines.svh"

module fragmentFormatter
(
    input  logic                    clk,
    input  logic                    reset,
    input  rasterizerPkg::pixelPosT pos,
    input  logic                    posValid,
    output logic                    posReady,
    output rasterizerPkg::fragmentT frag,
    output logic                    fragValid,
    input  logic                    fragReady
);
    rasterizerPkg::fragmentT nextFrag;

    // Lines are stored bottom up, so line 0 of the band is the last row
    always_comb
    begin
        nextFrag.fbIndex = `FB_INDEX_WIDTH'(
            ((`Y_LINE_RESOLUTION - 1) - 32'(pos.yRel)) * `X_RESOLUTION + 32'(pos.x));
        nextFrag.screenX = 16'(pos.x);
        nextFrag.screenY = 16'(pos.yScreen);
        nextFrag.relX    = 16'(pos.x) - 16'(pos.bbStartX);
        nextFrag.relY    = 16'(pos.yScreen) - 16'(pos.bbStartY);
    end

    // The register can take a new pixel when empty or when it drains this cycle
    assign posReady = !fragValid || fragReady;

    always_ff @(posedge clk)
    begin
        if (reset)
            fragValid <= 1'b0;
        else if (posReady)
            fragValid <= posValid;
    end

    // Held stable while a fragment waits for fragReady
    always_ff @(posedge clk)
    begin
        if (posReady && posValid)
            frag <= nextFrag;
    end

endmodule

// ==== hw/rasterizer.sv ====
// Rasterizer top level
// Setup, edge walker and fragment formatter in a three stage pipeline
`timescale 1ns/1ps

module rasterizer
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  rasterizerPkg::triangleT triangle,
    output logic                    running,
    output rasterizerPkg::fragmentT frag,
    output logic                    fragValid,
    input  logic                    fragReady
);
    rasterizerPkg::walkJobT   job;
    rasterizerPkg::pixelPosT  pos;

    logic startAccepted;
    logic jobValid;
    logic setupBusy;
    logic walkerIdle;
    logic posValid;
    logic posReady;

    // A new triangle is only taken once the previous one has fully drained
    assign startAccepted = start && !running;

    // Busy while any stage still holds work, including an unsent fragment
    assign running = setupBusy || !walkerIdle || fragValid;

    triangleSetup setup
    (
        .clk        (clk),
        .reset      (reset),
        .start      (startAccepted),
        .triangle   (triangle),
        .walkerIdle (walkerIdle),
        .job        (job),
        .jobValid   (jobValid),
        .busy       (setupBusy)
    );

    edgeWalker walker
    (
        .clk        (clk),
        .reset      (reset),
        .job        (job),
        .jobValid   (jobValid),
        .walkerIdle (walkerIdle),
        .pos        (pos),
        .posValid   (posValid),
        .posReady   (posReady)
    );

    fragmentFormatter formatter
    (
        .clk        (clk),
        .reset      (reset),
        .pos        (pos),
        .posValid   (posValid),
        .posReady   (posReady),
        .frag       (frag),
        .fragValid  (fragValid),
        .fragReady  (fragReady)
    );

endmodule

// ==== hw/rasterizerPkg.sv ====
// Data types shared by the rasterizer stages
// Triangle, setup job, pixel position and fragment structs plus the FSM enums
`include "rasterizer_defines.svh"

package rasterizerPkg;

    typedef logic [`COORD_WIDTH-1:0] coordT;
    typedef logic [`ATTR_WIDTH-1:0] attrT;

    // Triangle as it arrives from the command side
    typedef struct packed {
        coordT bbStartX;
        coordT bbStartY;
        coordT bbEndX;
        coordT bbEndY;
        coordT offsetY;
        attrT  w0;
        attrT  w1;
        attrT  w2;
        attrT  w0IncX;
        attrT  w1IncX;
        attrT  w2IncX;
        attrT  w0IncY;
        attrT  w1IncY;
        attrT  w2IncY;
    } triangleT;

    // Start point of the walk after clipping to the line band
    typedef struct packed {
        coordT startX;
        coordT yScreen;
        coordT yScreenEnd;
        coordT yRel;
        attrT  w0;
        attrT  w1;
        attrT  w2;
        coordT bbStartX;
        coordT bbEndX;
        coordT bbStartY;
        attrT  w0IncX;
        attrT  w1IncX;
        attrT  w2IncX;
        attrT  w0IncY;
        attrT  w1IncY;
        attrT  w2IncY;
    } walkJobT;

    // One covered pixel, with the box origin for relative coordinates
    typedef struct packed {
        coordT x;
        coordT yScreen;
        coordT yRel;
        coordT bbStartX;
        coordT bbStartY;
    } pixelPosT;

    typedef struct packed {
        logic [`FB_INDEX_WIDTH-1:0] fbIndex;
        logic [15:0] screenX;
        logic [15:0] screenY;
        logic [15:0] relX;
        logic [15:0] relY;
    } fragmentT;

    typedef enum logic [2:0] {walkInit, searchEdge, walkOut, walk, checkDir} walkStateT;
    typedef enum logic {left, right} walkDirT;
    typedef enum logic {idle, busy} setupStateT;

endpackage

// ==== hw/rasterizer_defines.svh ====
// Screen resolution, band height and data width macros for the rasterizer
// Shared by the package and every module that sizes its own arithmetic
`ifndef RASTERIZER_DEFINES_SVH
`define RASTERIZER_DEFINES_SVH

// Screen size in pixels
`define X_RESOLUTION 128
`define Y_RESOLUTION 128

// Number of screen lines rendered in one pass, starting at offsetY
`define Y_LINE_RESOLUTION 128

// Width of the linear framebuffer index inside one band
`define FB_INDEX_WIDTH 14

// Width of an edge function value and of its increments
`define ATTR_WIDTH 32

// Width of a screen coordinate, log2 of the resolution plus one spare bit
// The spare bit lets x step one past the box edge without wrapping
`define COORD_WIDTH 8

`endif

// ==== hw/triangleSetup.sv ====
// Triangle setup stage
// Captures a triangle on start and clips its walk to the current line band
`timescale 1ns/1ps
`include "rasterizer_defines.svh"

module triangleSetup
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  rasterizerPkg::triangleT triangle,
    input  logic                    walkerIdle,
    output rasterizerPkg::walkJobT  job,
    output logic                    jobValid,
    output logic                    busy
);
    rasterizerPkg::setupStateT state;
    rasterizerPkg::triangleT   triReg;

    // The band top lies below the box top, so the first lines are skipped
    logic clipTop;
    // Number of skipped lines when clipTop is set
    logic [`COORD_WIDTH-1:0] lineDiff;
    // One extra bit so offsetY plus the band height cannot wrap
    logic [`COORD_WIDTH:0] bandEnd;

    // Advances an edge value over the skipped lines with a single multiply
    function automatic logic [`ATTR_WIDTH-1:0] clipEdge(
        input logic [`ATTR_WIDTH-1:0]  w,
        input logic [`ATTR_WIDTH-1:0]  incY,
        input logic [`COORD_WIDTH-1:0] lines
    );
        logic signed [`ATTR_WIDTH-1:0] step;
        step = $signed(incY) * $signed({1'b0, lines});
        return w + step;
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= rasterizerPkg::idle;
        end
        else
        begin
            case (state)
            rasterizerPkg::idle:
            begin
                if (start)
                    state <= rasterizerPkg::busy;
            end
            default:
            begin
                // Job handed over once the walker has room for it
                if (walkerIdle)
                    state <= rasterizerPkg::idle;
            end
            endcase
        end
    end

    // The triangle is sampled once, later changes on the inputs are ignored
    always_ff @(posedge clk)
    begin
        if (start && (state == rasterizerPkg::idle))
            triReg <= triangle;
    end

    assign clipTop  = triReg.offsetY > triReg.bbStartY;
    assign lineDiff = triReg.offsetY - triReg.bbStartY;
    assign bandEnd  = {1'b0, triReg.offsetY} + (`COORD_WIDTH+1)'(`Y_LINE_RESOLUTION);

    always_comb
    begin
        job.startX     = triReg.bbStartX;
        job.yScreen    = clipTop ? triReg.offsetY : triReg.bbStartY;
        job.yRel       = clipTop ? '0 : triReg.bbStartY - triReg.offsetY;
        // Stop at the band end or at the box end, whichever comes first
        job.yScreenEnd = (bandEnd < {1'b0, triReg.bbEndY}) ? bandEnd[`COORD_WIDTH-1:0]
                                                           : triReg.bbEndY;
        job.w0         = clipTop ? clipEdge(triReg.w0, triReg.w0IncY, lineDiff) : triReg.w0;
        job.w1         = clipTop ? clipEdge(triReg.w1, triReg.w1IncY, lineDiff) : triReg.w1;
        job.w2         = clipTop ? clipEdge(triReg.w2, triReg.w2IncY, lineDiff) : triReg.w2;
        job.bbStartX   = triReg.bbStartX;
        job.bbEndX     = triReg.bbEndX;
        job.bbStartY   = triReg.bbStartY;
        job.w0IncX     = triReg.w0IncX;
        job.w1IncX     = triReg.w1IncX;
        job.w2IncX     = triReg.w2IncX;
        job.w0IncY     = triReg.w0IncY;
        job.w1IncY     = triReg.w1IncY;
        job.w2IncY     = triReg.w2IncY;
    end

    // The job is ready one cycle after start and stays valid until taken
    assign jobValid = (state == rasterizerPkg::busy);
    assign busy     = (state == rasterizerPkg::busy);

endmodule

// ==== tb/rasterizerRef.svh ====
// Coverage reference for a triangle and the expected fields of each fragment
// Typed compare tasks for fragments and fragment counts
`ifndef RASTERIZER_REF_SVH
`define RASTERIZER_REF_SVH

// Edge value at a pixel, stepped from the value at the box start
function automatic int edgeAt(input logic [31:0] w, input logic [31:0] incX,
                              input logic [31:0] incY, input int dx, input int dy);
    return int'(w) + int'(incX) * dx + int'(incY) * dy;
endfunction

// Fills expectedCov for the whole screen and returns the number of covered pixels
function automatic int markCoverage(input rasterizerPkg::triangleT t);
    int  x;
    int  y;
    int  dx;
    int  dy;
    int  yFirst;
    int  yEnd;
    int  count;
    bit  covered;
    // Lines above the band are skipped, the band and the box both cut the bottom
    yFirst = (t.offsetY > t.bbStartY) ? int'(t.offsetY) : int'(t.bbStartY);
    yEnd   = int'(t.offsetY) + `Y_LINE_RESOLUTION;
    if (int'(t.bbEndY) < yEnd)
        yEnd = int'(t.bbEndY);
    count = 0;
    for (y = 0; y < `Y_RESOLUTION; y++)
    begin
        for (x = 0; x < `X_RESOLUTION; x++)
        begin
            dx = x - int'(t.bbStartX);
            dy = y - int'(t.bbStartY);
            covered = (y >= yFirst) && (y < yEnd) && (dx >= 0) && (x < int'(t.bbEndX))
                      && (edgeAt(t.w0, t.w0IncX, t.w0IncY, dx, dy) >= 0)
                      && (edgeAt(t.w1, t.w1IncX, t.w1IncY, dx, dy) >= 0)
                      && (edgeAt(t.w2, t.w2IncX, t.w2IncY, dx, dy) >= 0);
            expectedCov[y][x] = covered;
            if (covered)
                count++;
        end
    end
    return count;
endfunction

// Line 0 of the band is stored as the last framebuffer row
function automatic rasterizerPkg::fragmentT expectedFragment(
    input rasterizerPkg::triangleT t, input int x, input int y);
    rasterizerPkg::fragmentT f;
    int bandLine;
    bandLine  = y - int'(t.offsetY);
    f.fbIndex = `FB_INDEX_WIDTH'((`Y_LINE_RESOLUTION - 1 - bandLine) * `X_RESOLUTION + x);
    f.screenX = 16'(x);
    f.screenY = 16'(y);
    f.relX    = 16'(x - int'(t.bbStartX));
    f.relY    = 16'(y - int'(t.bbStartY));
    return f;
endfunction

function automatic string fragText(input rasterizerPkg::fragmentT f);
    return $sformatf("fbIndex %0d at (%0d,%0d) rel (%0d,%0d)",
                     f.fbIndex, f.screenX, f.screenY, f.relX, f.relY);
endfunction

task automatic compareFragment(input string name, input rasterizerPkg::fragmentT expected,
                               input rasterizerPkg::fragmentT actual);
    if (actual !== expected)
    begin
        testErrors++;
        $display("error %s: expected %s, actual %s", name, fragText(expected),
                 fragText(actual));
    end
endtask

task automatic compareCount(input string name, input int expected, input int actual);
    if (actual != expected)
    begin
        testErrors++;
        $display("error %s: expected %0d fragments, actual %0d", name, expected, actual);
    end
endtask

`endif

// ==== tb/rasterizerTb.sv ====
// Testbench for the rasterizer with a coverage reference and a fragment checker
// Covers reset, full, clipped, stalled, empty and back to back triangles
`timescale 1ns/1ps
`include "rasterizer_defines.svh"

module rasterizerTb;

    localparam int timeoutCycles = 20000;

    logic                    clk;
    logic                    reset;
    logic                    start;
    logic                    fragReady = 1'b1;
    logic                    running;
    logic                    fragValid;
    rasterizerPkg::triangleT triangle;
    rasterizerPkg::fragmentT frag;

    // Reference coverage of the triangle under test and the pixels already received
    bit                      expectedCov [0:`Y_RESOLUTION-1][0:`X_RESOLUTION-1];
    bit                      seenPixels [int];
    rasterizerPkg::triangleT activeTri;
    string                   testName;
    int                      fragCount;
    int                      testErrors;
    int                      testsRun;
    int                      testsFailed;
    bit                      randomReady;
    logic [31:0]             lcgState = 32'h1c11;

    // Fragment that waited for fragReady on the last edge
    bit                      holdValid;
    rasterizerPkg::fragmentT heldFrag;

    `include "rasterizerRef.svh"

    rasterizer UUT
    (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .triangle  (triangle),
        .running   (running),
        .frag      (frag),
        .fragValid (fragValid),
        .fragReady (fragReady)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Back-pressure is either off or a coin toss from the upper LCG bits
    always @(negedge clk)
    begin
        if (randomReady)
        begin
            lcgState = lcgNext(lcgState);
            fragReady <= lcgState[24];
        end
        else
            fragReady <= 1'b1;
    end

    task automatic noteFailure(input string msg);
        testErrors++;
        $display("%s: %s", testName, msg);
    endtask

    task automatic abortRun(input string reason);
        $display("%s: %s", testName, reason);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic checkFragment(input rasterizerPkg::fragmentT f);
        int x;
        int y;
        int key;
        x   = int'(f.screenX);
        y   = int'(f.screenY);
        key = y * `X_RESOLUTION + x;
        fragCount++;
        if ((x >= `X_RESOLUTION) || (y >= `Y_RESOLUTION))
            noteFailure($sformatf("fragment at (%0d,%0d) lies off screen", x, y));
        else if (!expectedCov[y][x])
            noteFailure($sformatf("fragment at (%0d,%0d) is not covered", x, y));
        else if (seenPixels.exists(key))
            noteFailure($sformatf("fragment at (%0d,%0d) was sent twice", x, y));
        else
        begin
            seenPixels[key] = 1'b1;
            compareFragment(testName, expectedFragment(activeTri, x, y), f);
        end
    endtask

    // Sampled at the rising edge, where a fragment either transfers or is held
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (holdValid && !fragValid)
                noteFailure("fragValid dropped before the held fragment was taken");
            else if (holdValid && (frag !== heldFrag))
                noteFailure("frag changed while it waited for fragReady");
            if (fragValid && fragReady)
                checkFragment(frag);
            holdValid = fragValid && !fragReady;
            heldFrag  = frag;
        end
    end

    task automatic closeTest();
        testsRun++;
        if (testErrors != 0)
            testsFailed++;
        $display("test %s: %0d fragments, %0d errors", testName, fragCount, testErrors);
    endtask

    // Starts one triangle and waits until the whole pipeline has drained
    task automatic runTriangle(input string name, input rasterizerPkg::triangleT t,
                               input bit stall);
        int expectedCount;
        int cycles;
        @(posedge clk);
        randomReady = stall;
        @(negedge clk);
        testName      = name;
        testErrors    = 0;
        fragCount     = 0;
        activeTri     = t;
        seenPixels.delete();
        expectedCount = markCoverage(t);
        triangle      = t;
        start         = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        cycles = 0;
        while (!running && (cycles < 4))
        begin
            @(negedge clk);
            cycles++;
        end
        if (!running)
            abortRun("running did not rise after start");
        cycles = 0;
        while (running && (cycles < timeoutCycles))
        begin
            @(negedge clk);
            cycles++;
        end
        if (running)
            abortRun("running still high after the timeout");
        compareCount(name, expectedCount, fragCount);
        closeTest();
    endtask

    function automatic rasterizerPkg::triangleT makeTriangle(
        input int sx, input int sy, input int ex, input int ey, input int offY,
        input int w0, input int w1, input int w2,
        input int ix0, input int ix1, input int ix2,
        input int iy0, input int iy1, input int iy2);
        rasterizerPkg::triangleT t;
        t.bbStartX = `COORD_WIDTH'(sx);
        t.bbStartY = `COORD_WIDTH'(sy);
        t.bbEndX   = `COORD_WIDTH'(ex);
        t.bbEndY   = `COORD_WIDTH'(ey);
        t.offsetY  = `COORD_WIDTH'(offY);
        t.w0       = w0;
        t.w1       = w1;
        t.w2       = w2;
        t.w0IncX   = ix0;
        t.w1IncX   = ix1;
        t.w2IncX   = ix2;
        t.w0IncY   = iy0;
        t.w1IncY   = iy1;
        t.w2IncY   = iy2;
        return t;
    endfunction

    initial
    begin
        int                      i;
        rasterizerPkg::triangleT rightTri;
        rasterizerPkg::triangleT clippedTri;
        rasterizerPkg::triangleT emptyTri;
        rasterizerPkg::triangleT slopedTri;
        // Edges x >= 12, y >= 12 and x + y <= 40 inside a box from (10,10) to (34,34)
        rightTri   = makeTriangle(10, 10, 34, 34, 0, -2, -2, 20, 1, 0, -1, 0, 1, -1);
        // Same triangle with the band starting six lines below the box top
        clippedTri = makeTriangle(10, 10, 34, 34, 16, -2, -2, 20, 1, 0, -1, 0, 1, -1);
        // First edge is negative everywhere
        emptyTri   = makeTriangle(20, 20, 30, 26, 0, -100, 100, 100, 0, 0, 0, 0, 0, 0);
        // Vertices (40,40), (62,46) and (48,60), all three edges slanted
        slopedTri  = makeTriangle(40, 40, 63, 61, 0, 0, 392, 0, -6, -14, 20, 22, -14, -8);

        reset    = 1'b1;
        start    = 1'b0;
        triangle = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Nothing may move before the first start
        testName   = "resetIdle";
        testErrors = 0;
        fragCount  = 0;
        for (i = 0; i < 16; i++)
        begin
            @(negedge clk);
            if ((running !== 1'b0) || (fragValid !== 1'b0))
                noteFailure("running or fragValid went high without a start");
        end
        closeTest();

        runTriangle("fullTriangle", rightTri, 1'b0);
        runTriangle("clippedTop", clippedTri, 1'b0);
        runTriangle("randomReady", rightTri, 1'b1);
        runTriangle("emptyBox", emptyTri, 1'b0);
        runTriangle("sequenceFirst", slopedTri, 1'b0);
        runTriangle("sequenceSecond", rightTri, 1'b0);

        $display("tests run %0d, failed %0d", testsRun, testsFailed);
        if (testsFailed == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
